// File: uart_echo_pkg.sv
package uart_echo_pkg;

    // line timing
    localparam int CLK_FREQ_HZ  = 50_000_000;             // board oscillator
    localparam int BAUD_RATE    = 115_200;
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE; // 434, truncated
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;       // 217, bit centre
    localparam int DATA_BITS    = 8;                      // 8N1 only

    // counter width covers 0 .. CLKS_PER_BIT-1
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    typedef logic [DATA_BITS-1:0]         byte_t;      // one serial data byte
    typedef logic [BAUD_CNT_W-1:0]        baud_cnt_t;  // bit-period counter
    typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;   // data bit position

    // receiver -> buffer, valid is a one-cycle strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_byte_t;

    // buffer -> transmitter, start is a one-cycle strobe
    typedef struct packed {
        logic  start;
        byte_t data;
    } tx_req_t;

    typedef enum logic [1:0] {
        RX_IDLE,   // waiting for falling edge
        RX_START,  // checking start bit at its centre
        RX_DATA,   // sampling data bits, lsb first
        RX_STOP    // stop bit check
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,  // line held low for one bit
        TX_DATA,
        TX_STOP    // line high, busy until its end
    } tx_state_e;

endpackage

// File: baud_timer.sv
module baud_timer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic run_i,       // level from the owning fsm
    output logic mid_tick_o,  // bit centre
    output logic bit_tick_o   // end of bit period
);

    uart_echo_pkg::baud_cnt_t cnt_q;
    logic                     wrap;
    logic                     mid;

    // count value 0 lines up with the cycle run_i goes high
    assign wrap = (cnt_q == uart_echo_pkg::baud_cnt_t'(uart_echo_pkg::CLKS_PER_BIT - 1));
    assign mid  = (cnt_q == uart_echo_pkg::baud_cnt_t'(uart_echo_pkg::HALF_BIT));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;              // parked while the line is idle
        end else if (wrap) begin
            cnt_q <= '0;              // next bit period
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // ticks only while running, so a stale count after stop
    // can never fire a spurious pulse
    assign mid_tick_o = run_i & mid;
    assign bit_tick_o = run_i & wrap;   // last cycle of each bit

endmodule

// File: uart_rx.sv
module uart_rx (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    rxd_i,      // async serial line
    output uart_echo_pkg::rx_byte_t rx_byte_o
);

    logic [1:0]                rx_sync_q;   // 2-flop synchronizer
    logic                      rx_s;        // synchronized line
    logic                      rx_prev_q;   // for edge detect
    logic                      rx_fall;
    uart_echo_pkg::rx_state_e  state_q;
    uart_echo_pkg::bit_idx_t   bit_idx_q;
    uart_echo_pkg::byte_t      shift_q;
    logic                      valid_q;
    logic                      run;
    logic                      mid_tick;

    // line idles high, so sync flops come out of reset high
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_sync_q <= 2'b11;
            rx_prev_q <= 1'b1;
        end else begin
            rx_sync_q <= {rx_sync_q[0], rxd_i};
            rx_prev_q <= rx_s;
        end
    end

    assign rx_s    = rx_sync_q[1];
    assign rx_fall = rx_prev_q & ~rx_s;   // start bit leading edge

    assign run = (state_q != uart_echo_pkg::RX_IDLE);

    // rx works on bit centres only
    baud_timer i_baud_timer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .run_i      (run),
        .mid_tick_o (mid_tick),
        .bit_tick_o ()
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= uart_echo_pkg::RX_IDLE;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;   // strobe, one cycle only
            case (state_q)
                uart_echo_pkg::RX_IDLE: begin
                    if (rx_fall) begin
                        state_q <= uart_echo_pkg::RX_START;
                    end
                end
                uart_echo_pkg::RX_START: begin
                    if (mid_tick) begin
                        // glitch shorter than half a bit goes back to idle
                        state_q   <= rx_s ? uart_echo_pkg::RX_IDLE : uart_echo_pkg::RX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                uart_echo_pkg::RX_DATA: begin
                    if (mid_tick) begin
                        if (bit_idx_q == uart_echo_pkg::bit_idx_t'(uart_echo_pkg::DATA_BITS - 1)) begin
                            state_q <= uart_echo_pkg::RX_STOP;
                        end
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                end
                uart_echo_pkg::RX_STOP: begin
                    if (mid_tick) begin
                        valid_q <= rx_s;   // low stop bit means framing error, dropped
                        state_q <= uart_echo_pkg::RX_IDLE;
                    end
                end
                default: state_q <= uart_echo_pkg::RX_IDLE;
            endcase
        end
    end

    // data shifts in from the top, lsb arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == uart_echo_pkg::RX_DATA && mid_tick) begin
            shift_q <= {rx_s, shift_q[uart_echo_pkg::DATA_BITS-1:1]};
        end
    end

    // shift register holds still in idle, so data is stable with the strobe
    assign rx_byte_o.valid = valid_q;
    assign rx_byte_o.data  = shift_q;

endmodule

// File: uart_tx.sv
module uart_tx (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_echo_pkg::tx_req_t tx_req_i,
    output logic                   txd_o,    // serial line, registered
    output logic                   busy_o    // high while a frame is on the line
);

    uart_echo_pkg::tx_state_e state_q;
    uart_echo_pkg::bit_idx_t  bit_idx_q;
    uart_echo_pkg::byte_t     shift_q;
    logic                     txd_q;
    logic                     run;
    logic                     bit_tick;

    assign run = (state_q != uart_echo_pkg::TX_IDLE);

    // tx only steps on bit ends
    baud_timer i_baud_timer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .run_i      (run),
        .mid_tick_o (),
        .bit_tick_o (bit_tick)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= uart_echo_pkg::TX_IDLE;
            bit_idx_q <= '0;
            txd_q     <= 1'b1;   // idle line
        end else begin
            case (state_q)
                uart_echo_pkg::TX_IDLE: begin
                    if (tx_req_i.start) begin
                        state_q <= uart_echo_pkg::TX_START;
                        txd_q   <= 1'b0;   // start bit from next cycle
                    end
                end
                uart_echo_pkg::TX_START: begin
                    if (bit_tick) begin
                        state_q   <= uart_echo_pkg::TX_DATA;
                        bit_idx_q <= '0;
                        txd_q     <= shift_q[0];
                    end
                end
                uart_echo_pkg::TX_DATA: begin
                    if (bit_tick) begin
                        if (bit_idx_q == uart_echo_pkg::bit_idx_t'(uart_echo_pkg::DATA_BITS - 1)) begin
                            state_q <= uart_echo_pkg::TX_STOP;
                            txd_q   <= 1'b1;   // stop bit
                        end else begin
                            txd_q   <= shift_q[0];
                        end
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                end
                uart_echo_pkg::TX_STOP: begin
                    if (bit_tick) begin
                        state_q <= uart_echo_pkg::TX_IDLE;   // busy drops here
                    end
                end
                default: state_q <= uart_echo_pkg::TX_IDLE;
            endcase
        end
    end

    // payload shifter, loaded on launch and moved right at each bit end
    always_ff @(posedge clk_i) begin
        if (state_q == uart_echo_pkg::TX_IDLE && tx_req_i.start) begin
            shift_q <= tx_req_i.data;
        end else if (bit_tick && state_q != uart_echo_pkg::TX_STOP) begin
            shift_q <= {1'b0, shift_q[uart_echo_pkg::DATA_BITS-1:1]};
        end
    end

    assign txd_o  = txd_q;
    assign busy_o = run;   // any state other than idle

endmodule

// File: echo_buffer.sv
module echo_buffer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  uart_echo_pkg::rx_byte_t rx_byte_i,
    input  logic                    tx_busy_i,   // level from uart_tx
    output uart_echo_pkg::tx_req_t  tx_req_o
);

    uart_echo_pkg::byte_t buf_q;      // last good byte from the line
    uart_echo_pkg::byte_t tx_data_q;  // byte handed to the transmitter
    logic                 avail_q;    // buffer holds an unsent byte
    logic                 start_q;
    logic                 launch;

    // busy rises only one cycle after start, start_q covers that gap
    assign launch = avail_q & ~tx_busy_i & ~start_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            avail_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= launch;   // one-cycle strobe
            if (rx_byte_i.valid) begin
                avail_q <= 1'b1;   // new byte wins over the clear
            end else if (launch) begin
                avail_q <= 1'b0;
            end
        end
    end

    // unsent byte is overwritten, no back-pressure toward the line
    always_ff @(posedge clk_i) begin
        if (rx_byte_i.valid) begin
            buf_q <= rx_byte_i.data;
        end
    end

    // separate copy so a byte arriving with the launch cannot
    // replace the one being sent
    always_ff @(posedge clk_i) begin
        if (launch) begin
            tx_data_q <= buf_q;
        end
    end

    assign tx_req_o.start = start_q;
    assign tx_req_o.data  = tx_data_q;

endmodule

// File: uart_echo_top.sv
module uart_echo_top (
    input  logic clk_i,
    input  logic rst_i,
    input  logic rxd_i,   // serial in, asynchronous
    output logic txd_o    // serial out, echo of each good frame
);

    // receiver to buffer, strobe plus byte
    uart_echo_pkg::rx_byte_t rx_byte;

    // buffer to transmitter, launch plus byte
    uart_echo_pkg::tx_req_t  tx_req;

    // transmitter back to buffer
    logic                    tx_busy;

    // frames in, bad stop bits filtered here
    uart_rx i_uart_rx (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rxd_i     (rxd_i),
        .rx_byte_o (rx_byte)
    );

    // one-byte store and launch control
    echo_buffer i_echo_buffer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rx_byte_i (rx_byte),
        .tx_busy_i (tx_busy),
        .tx_req_o  (tx_req)
    );

    // frames out, start bit begins the cycle after launch
    uart_tx i_uart_tx (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tx_req_i (tx_req),
        .txd_o    (txd_o),
        .busy_o   (tx_busy)
    );

endmodule

// File: uart_echo_props.sv
module uart_echo_props (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    txd_i,      // top level serial out
    input logic                    busy_i,     // transmitter busy level
    input uart_echo_pkg::tx_req_t  tx_req_i,   // buffer launch
    input uart_echo_pkg::rx_byte_t rx_byte_i   // receiver strobe
);

    timeunit 1ns;
    timeprecision 1ps;

    // idle transmitter keeps the line high
    idle_line_high: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !busy_i |-> txd_i
    ) else $error("txd_o low while transmitter idle");

    // launch only reaches an idle transmitter
    no_start_when_busy: assert property (
        @(posedge clk_i) disable iff (rst_i)
        tx_req_i.start |-> !busy_i
    ) else $error("transmit start raised while busy");

    // receive strobe is a single cycle
    rx_valid_one_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rx_byte_i.valid |=> !rx_byte_i.valid
    ) else $error("receive valid held for two cycles");

endmodule

bind uart_echo_top uart_echo_props i_uart_echo_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .txd_i     (txd_o),
    .busy_i    (tx_busy),
    .tx_req_i  (tx_req),
    .rx_byte_i (rx_byte)
);

// File: tb_uart_echo.sv
module tb_uart_echo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 10;
    localparam int BIT_CLKS      = uart_echo_pkg::CLKS_PER_BIT;
    localparam int N_ENTRIES     = 14;
    localparam int N_FIXED       = 7;   // hand-picked entries, rest random
    localparam int GAP_BITS      = 2;   // idle line between frames
    localparam int DRAIN_BITS    = 12;
    localparam int IDLE_BITS     = 20;  // quiet window after reset

    // budget is twice a generous per-frame length
    localparam int WATCHDOG_NS = N_ENTRIES * 14 * BIT_CLKS * CLK_PERIOD_NS * 2;

    // one table row: frame byte, stop bit level, echo expected
    typedef struct packed {
        uart_echo_pkg::byte_t data;
        logic                 stop_ok;
        logic                 echo;
    } stim_t;

    logic clk_i;
    logic rst_i;
    logic rxd_i;
    logic txd_o;

    stim_t                stim_tab [N_ENTRIES];
    uart_echo_pkg::byte_t exp_q [$];   // bytes still owed on txd_o
    uart_echo_pkg::byte_t got_q [$];   // bytes decoded by the monitor
    int                   n_decoded;
    int                   n_good;
    integer               seed;

    uart_echo_top i_uart_echo_top (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .rxd_i (rxd_i),
        .txd_o (txd_o)
    );

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string msg);
        if (expected !== actual) begin
            $display("CHECK FAILED at time %0t: %s, expected 0x%0h, got 0x%0h",
                     $time, msg, expected, actual);
            abort_run();
        end
    endtask

    // returns 1 ns past a rising edge, the drive point
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic send_bit(input logic b);
        rxd_i = b;
        wait_cycles(BIT_CLKS);   // one full bit period
    endtask

    // 8N1 frame, lsb first, stop level chosen by caller
    task automatic send_frame(input uart_echo_pkg::byte_t data, input logic stop_ok);
        send_bit(1'b0);
        for (int i = 0; i < uart_echo_pkg::DATA_BITS; i++) begin
            send_bit(data[i]);
        end
        send_bit(stop_ok);
        rxd_i = 1'b1;   // back to idle
    endtask

    task automatic fill_table();
        stim_tab[0] = '{data: 8'h5A, stop_ok: 1'b1, echo: 1'b1};   // single frame case
        stim_tab[1] = '{data: 8'h00, stop_ok: 1'b1, echo: 1'b1};
        stim_tab[2] = '{data: 8'hFF, stop_ok: 1'b1, echo: 1'b1};
        stim_tab[3] = '{data: 8'h55, stop_ok: 1'b1, echo: 1'b1};
        stim_tab[4] = '{data: 8'hA5, stop_ok: 1'b1, echo: 1'b1};
        stim_tab[5] = '{data: 8'h3C, stop_ok: 1'b0, echo: 1'b0};   // framing error, dropped
        stim_tab[6] = '{data: 8'hC3, stop_ok: 1'b1, echo: 1'b1};   // must still get through
        for (int i = N_FIXED; i < N_ENTRIES; i++) begin
            stim_tab[i].data    = 8'($random(seed));
            stim_tab[i].stop_ok = 1'b1;
            stim_tab[i].echo    = 1'b1;
        end
    endtask

    // serial monitor on txd_o, samples near each bit centre
    initial begin : decode_txd
        uart_echo_pkg::byte_t data;
        forever begin
            @(negedge txd_o);
            repeat (uart_echo_pkg::HALF_BIT) @(negedge clk_i);
            check(32'(1'b0), 32'(txd_o), "echo start bit not low at its centre");
            for (int i = 0; i < uart_echo_pkg::DATA_BITS; i++) begin
                repeat (BIT_CLKS) @(negedge clk_i);
                data[i] = txd_o;   // lsb first
            end
            repeat (BIT_CLKS) @(negedge clk_i);
            check(32'(1'b1), 32'(txd_o), "echo stop bit not high");
            got_q.push_back(data);
            n_decoded++;
        end
    end

    // pairs each decoded byte with the oldest outstanding good frame
    initial begin : compare_echo
        uart_echo_pkg::byte_t got;
        uart_echo_pkg::byte_t exp;
        forever begin
            @(negedge clk_i);
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                check(32'(1'b1), 32'(exp_q.size() > 0), "byte echoed with no good frame pending");
                exp = exp_q.pop_front();
                check(32'(exp), 32'(got), "echoed byte differs from frame sent");
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, echo traffic did not finish", WATCHDOG_NS);
        abort_run();
    end

    initial begin : main
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        rxd_i     = 1'b1;   // idle line
        n_decoded = 0;
        n_good    = 0;
        seed      = 32'hdcd6_3949;
        fill_table();

        // reset for 8 edges, line must idle high throughout
        repeat (8) begin
            @(posedge clk_i);
            #1;
            check(32'(1'b1), 32'(txd_o), "txd_o not high during reset");
        end
        rst_i = 1'b0;

        // quiet window, nothing should come out
        repeat (IDLE_BITS * BIT_CLKS) begin
            @(negedge clk_i);
            check(32'(1'b1), 32'(txd_o), "txd_o left idle with no input");
        end
        check(32'(0), 32'(n_decoded), "byte decoded while rxd_i idle");

        @(posedge clk_i);
        #1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (stim_tab[i].echo) begin
                exp_q.push_back(stim_tab[i].data);
                n_good++;
            end
            send_frame(stim_tab[i].data, stim_tab[i].stop_ok);
            wait_cycles(GAP_BITS * BIT_CLKS);
        end

        wait_cycles(DRAIN_BITS * BIT_CLKS);   // last echo fully out
        check(32'(n_good), 32'(n_decoded), "echo count differs from good frames");
        check(32'(0), 32'(got_q.size()), "decoded bytes left unchecked");
        check(32'(0), 32'(exp_q.size()), "good frames never echoed");

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: compile.f
uart_echo_pkg.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
echo_buffer.sv
uart_echo_top.sv
uart_echo_props.sv
tb_uart_echo.sv

// File: Makefile
# Verilator build and run for the serial echo testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_echo
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
